// ==== mac_unit.f ====
+incdir+.
mac_data_pkg.sv
mac_op_pkg.sv
dsp_slice.sv
alu_dsp.sv
mac_ctrl_regs.sv
mac_unit_top.sv
mac_unit_checker.sv
tb_mac_unit.sv

// ==== Bender.yml ====
package:
  name: mac_unit

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mac_data_pkg.sv
      - mac_op_pkg.sv
      - dsp_slice.sv
      - alu_dsp.sv
      - mac_ctrl_regs.sv
      - mac_unit_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - mac_unit_checker.sv
      - tb_mac_unit.sv

// ==== tb_mac_unit.sv ====
// MAC unit testbench
// Directed tests with a reference model of P = Z +/- (X + carry),
// result order and latency checks, watchdog and summary
`timescale 1ns/1ps
`include "mac_consts.svh"

module tb_mac_unit
    import mac_data_pkg::*;
    import mac_op_pkg::*;
;

    localparam int CLK_PERIOD   = 40;
    localparam int DRAIN_LIMIT  = 10;  // Cycles to wait for the last results
    localparam int RUN_CYCLES   = 3 + 10 + 25 + 28 + 55 + 16 + 7;  // Reset plus each test
    localparam int MARGIN_CYCLES = 100;

    logic     reset;      // Clock
    logic     clk;        // Async reset, active high
    logic     wr_en;
    logic     wr_addr;
    result_t  wr_data;
    logic     in_valid;
    operand_t a;
    operand_t b;
    result_t  p;
    logic     out_valid;

    // Reference state
    mac_op_t  model_op;   // Mirrors the op register
    result_t  model_c;    // Mirrors the bias register
    result_t  model_p;    // P after the last issued item
    result_t  exp_p_q[$];
    int       exp_cyc_q[$];
    result_t  mon_exp_p;
    int       mon_exp_cyc;
    int       cyc;        // Falling edges since start
    logic [15:0] lfsr_state;

    string    cur_test;
    int       test_err_start;
    int       test_cnt;
    int       check_cnt;
    int       err_cnt;

    operand_t fix_a [0:3] = '{-18'sd5, 18'sd1000, 18'sh20000, 18'sd131071};
    operand_t fix_b [0:3] = '{18'sd7, -18'sd2000, 18'sh20000, 18'sd131071};
    result_t  bias_vals [0:2] = '{48'sd305419896, -48'sd987654321, 48'sd70000000000};

    mac_unit_top i_mac_unit_top (
        .reset     (reset    ),
        .clk       (clk      ),
        .wr_en     (wr_en    ),
        .wr_addr   (wr_addr  ),
        .wr_data   (wr_data  ),
        .in_valid  (in_valid ),
        .a         (a        ),
        .b         (b        ),
        .p         (p        ),
        .out_valid (out_valid)
    );

    bind mac_unit_top mac_unit_checker i_mac_unit_checker (
        .reset     (reset    ),
        .clk       (clk      ),
        .in_valid  (in_valid ),
        .p         (p        ),
        .out_valid (out_valid)
    );

    initial begin
        reset = 1'b0;
        forever #(CLK_PERIOD/2) reset = ~reset;
    end

    // --------------------
    // Stimulus helpers
    // --------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];  // x^16 + x^14 + x^13 + x^11
        return {s[14:0], fb};
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | lfsr_state[0];  // One step per bit
        end
        return v;
    endfunction

    function automatic mac_op_t make_op(input x_sel_e xs, input z_sel_e zs,
                                        input logic cin, input logic sub);
        mac_op_t o;
        o.x_sel    = xs;
        o.z_sel    = zs;
        o.carry_in = cin;
        o.subtract = sub;
        return o;
    endfunction

    // P = Z +/- (X + carry) with X and Z picked by the op word
    function automatic result_t model_result(input mac_op_t op, input operand_t av,
                                             input operand_t bv);
        result_t x_in;
        result_t z_in;
        case (op.x_sel)
            X_PROD:  x_in = result_t'(av) * result_t'(bv);
            X_P:     x_in = model_p;
            X_AB:    x_in = result_t'($signed({av, bv}));  // Sign-extended 36 bits
            default: x_in = '0;
        endcase
        case (op.z_sel)
            Z_P:     z_in = model_p;
            Z_C:     z_in = model_c;
            default: z_in = '0;
        endcase
        x_in = x_in + (op.carry_in ? 48'sd1 : 48'sd0);
        return op.subtract ? (z_in - x_in) : (z_in + x_in);
    endfunction

    // One clock of stimulus
    // An item sees the register values from before the write
    task automatic step(input logic issue, input operand_t av, input operand_t bv,
                        input logic wr, input logic addr, input result_t data);
        @(posedge reset);
        in_valid <= issue;
        a        <= av;
        b        <= bv;
        wr_en    <= wr;
        wr_addr  <= addr;
        wr_data  <= data;
        if (issue) begin
            model_p = model_result(model_op, av, bv);
            exp_p_q.push_back(model_p);
            exp_cyc_q.push_back(cyc + `MAC_LATENCY + 1);  // Sampled one edge after drive
        end
        if (wr && addr == `MAC_ADDR_OP)
            model_op = mac_op_t'(data[$bits(mac_op_t)-1:0]);
        else if (wr)
            model_c = data;
    endtask

    task automatic idle();
        step(1'b0, '0, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic write_reg(input logic addr, input result_t data);
        step(1'b0, '0, '0, 1'b1, addr, data);
    endtask

    task automatic issue_item(input operand_t av, input operand_t bv);
        step(1'b1, av, bv, 1'b0, 1'b0, '0);
    endtask

    task automatic issue_random();
        operand_t av;
        operand_t bv;
        av = operand_t'(rand_bits(`MAC_A_W));
        bv = operand_t'(rand_bits(`MAC_A_W));
        issue_item(av, bv);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_p_q.size() != 0 && waited < DRAIN_LIMIT) begin
            idle();
            waited++;
        end
        if (exp_p_q.size() != 0) begin
            $display("Test %s: %0d results never arrived", cur_test, exp_p_q.size());
            err_cnt++;
            exp_p_q.delete();
            exp_cyc_q.delete();
        end
    endtask

    task automatic report_mismatch(input result_t exp_v, input result_t act_v);
        $display("Fail %s: expected %0d, actual %0d", cur_test, exp_v, act_v);
        err_cnt++;
    endtask

    task automatic begin_test(input string name);
        cur_test       = name;
        test_err_start = err_cnt;
        test_cnt++;
    endtask

    task automatic end_test();
        $display("Test %s: %0d errors", cur_test, err_cnt - test_err_start);
    endtask

    // --------------------
    // Result monitor
    // --------------------
    always @(negedge reset) begin
        cyc = cyc + 1;
        if (clk === 1'b0 && out_valid !== 1'b0) begin
            if (exp_p_q.size() == 0) begin
                $display("Test %s: out_valid rose with no item in flight", cur_test);
                err_cnt++;
            end else begin
                mon_exp_p   = exp_p_q.pop_front();
                mon_exp_cyc = exp_cyc_q.pop_front();
                check_cnt++;
                if (p !== mon_exp_p)
                    report_mismatch(mon_exp_p, p);
                if (cyc != mon_exp_cyc) begin
                    $display("Test %s: result came at cycle %0d instead of cycle %0d",
                             cur_test, cyc, mon_exp_cyc);
                    err_cnt++;
                end
            end
        end
    end

    // --------------------
    // Tests
    // --------------------
    task automatic test_reset_state();
        begin_test("reset_state");
        @(negedge reset);
        check_cnt += 2;
        if (p !== '0)
            report_mismatch('0, p);
        if (out_valid !== 1'b0) begin
            $display("Test %s: out_valid high right after reset", cur_test);
            err_cnt++;
        end
        write_reg(`MAC_ADDR_C, 48'sd777);
        repeat (8) idle();
        @(negedge reset);
        check_cnt++;
        if (p !== '0)
            report_mismatch('0, p);  // Bias write alone must not touch P
        end_test();
    endtask

    task automatic test_multiply();
        begin_test("multiply");
        write_reg(`MAC_ADDR_OP, result_t'(make_op(X_PROD, Z_ZERO, 1'b0, 1'b0)));
        repeat (20) issue_random();  // Back to back
        drain();
        end_test();
    endtask

    task automatic test_bias_subtract();
        begin_test("bias_subtract");
        for (int k = 0; k < 3; k++) begin
            // Add, then subtract, then subtract with carry
            write_reg(`MAC_ADDR_C, bias_vals[k]);
            write_reg(`MAC_ADDR_OP, result_t'(make_op(X_PROD, Z_C, k == 2, k != 0)));
            for (int i = 0; i < 4; i++)
                issue_item(fix_a[i], fix_b[i]);
            repeat (2) issue_random();
        end
        drain();
        end_test();
    endtask

    task automatic test_accumulate();
        int gap;
        begin_test("accumulate");
        write_reg(`MAC_ADDR_OP, result_t'(make_op(X_ZERO, Z_ZERO, 1'b0, 1'b0)));
        issue_random();  // Clears P
        write_reg(`MAC_ADDR_OP, result_t'(make_op(X_PROD, Z_P, 1'b0, 1'b0)));
        for (int i = 0; i < 12; i++) begin
            issue_random();
            gap = rand_bits(2);
            repeat (gap) idle();  // Idle cycles must hold P
        end
        drain();
        end_test();
    endtask

    task automatic test_concat_feedback();
        begin_test("concat_feedback");
        write_reg(`MAC_ADDR_OP, result_t'(make_op(X_AB, Z_ZERO, 1'b0, 1'b0)));
        repeat (4) issue_random();
        write_reg(`MAC_ADDR_OP, result_t'(make_op(X_P, Z_P, 1'b0, 1'b0)));
        repeat (6) issue_random();  // P doubles each item
        drain();
        end_test();
    endtask

    task automatic test_write_timing();
        operand_t av;
        operand_t bv;
        begin_test("write_timing");
        write_reg(`MAC_ADDR_OP, result_t'(make_op(X_PROD, Z_ZERO, 1'b0, 1'b0)));
        av = operand_t'(rand_bits(`MAC_A_W));
        bv = operand_t'(rand_bits(`MAC_A_W));
        // Item and op write share a cycle so the item keeps the product
        step(1'b1, av, bv, 1'b1, `MAC_ADDR_OP,
             result_t'(make_op(X_AB, Z_ZERO, 1'b0, 1'b0)));
        issue_item(av, bv);
        drain();
        end_test();
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        clk        <= 1'b1;
        wr_en      <= 1'b0;
        wr_addr    <= 1'b0;
        wr_data    <= '0;
        in_valid   <= 1'b0;
        a          <= '0;
        b          <= '0;
        model_op   = mac_op_t'(`MAC_OP_HOLD);
        model_c    = '0;
        model_p    = '0;
        cyc        = 0;
        lfsr_state = 16'd89;
        test_cnt   = 0;
        check_cnt  = 0;
        err_cnt    = 0;
        cur_test   = "reset";
        repeat (3) @(posedge reset);
        clk <= 1'b0;
        test_reset_state();
        test_multiply();
        test_bias_subtract();
        test_accumulate();
        test_concat_feedback();
        test_write_timing();
        err_cnt += i_mac_unit_top.i_mac_unit_checker.fail_cnt;  // Bound assertion failures
        $display("Tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    initial begin
        #((RUN_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired in test %s, run did not complete", cur_test);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== mac_unit_checker.sv ====
// MAC unit assertion checker
// Bound to the top level, watches reset state, result latency
// and that p only moves together with out_valid
`timescale 1ns/1ps
`include "mac_consts.svh"

module mac_unit_checker
    import mac_data_pkg::*;
(
    input logic    reset,      // Clock
    input logic    clk,        // Async reset, active high
    input logic    in_valid,
    input result_t p,
    input logic    out_valid
);

    int fail_cnt = 0;  // Failed assertions so far

    // --------------------
    // Reset state
    // --------------------
    a_reset_zero: assert property (@(posedge reset) clk |-> (p == '0 && !out_valid))
        else begin
            $error("p or out_valid not zero while in reset");
            fail_cnt++;
        end

    a_release_zero: assert property (@(posedge reset) $fell(clk) |-> (p == '0 && !out_valid))
        else begin
            $error("p or out_valid not zero after reset release");
            fail_cnt++;
        end

    // --------------------
    // Latency and hold
    // --------------------
    a_valid_after: assert property (@(posedge reset) disable iff (clk)
        in_valid |-> ##(`MAC_LATENCY) out_valid)
        else begin
            $error("out_valid missing after an issued item");
            fail_cnt++;
        end

    a_valid_source: assert property (@(posedge reset) disable iff (clk)
        out_valid |-> $past(in_valid, `MAC_LATENCY))
        else begin
            $error("out_valid without an item issued before it");
            fail_cnt++;
        end

    a_p_hold: assert property (@(posedge reset) disable iff (clk)
        !out_valid |-> $stable(p))
        else begin
            $error("p changed while out_valid low");
            fail_cnt++;
        end

endmodule

// ==== mac_unit_top.sv ====
// MAC unit top level
// Register block feeding the pipelined multiply and post-add wrapper
`timescale 1ns/1ps

module mac_unit_top
    import mac_data_pkg::*;
    import mac_op_pkg::*;
(
    input  logic     reset,      // Clock
    input  logic     clk,        // Async reset, active high
    input  logic     wr_en,      // Register write strobe
    input  logic     wr_addr,
    input  result_t  wr_data,
    input  logic     in_valid,   // One pulse per operand pair
    input  operand_t a,
    input  operand_t b,
    output result_t  p,
    output logic     out_valid
);

    mac_op_t op_w;  // Per-cycle operation
    result_t c_w;   // Bias

    mac_ctrl_regs i_mac_ctrl_regs (
        .reset    (reset   ),
        .clk      (clk     ),
        .wr_en    (wr_en   ),
        .wr_addr  (wr_addr ),
        .wr_data  (wr_data ),
        .in_valid (in_valid),
        .op       (op_w    ),
        .c        (c_w     )
    );

    alu_dsp i_alu_dsp (
        .reset     (reset    ),
        .clk       (clk      ),
        .in_valid  (in_valid ),
        .op        (op_w     ),
        .a         (a        ),
        .b         (b        ),
        .c         (c_w      ),
        .p         (p        ),
        .out_valid (out_valid)
    );

endmodule

// ==== mac_ctrl_regs.sv ====
// MAC configuration registers
// Holds the operation word and the bias, written by a host strobe,
// and issues either the stored word or the idle word each cycle
`timescale 1ns/1ps
`include "mac_consts.svh"

module mac_ctrl_regs
    import mac_data_pkg::*;
    import mac_op_pkg::*;
(
    input  logic    reset,     // Clock
    input  logic    clk,       // Async reset, active high
    input  logic    wr_en,     // One-cycle write strobe
    input  logic    wr_addr,   // Operation or bias register
    input  result_t wr_data,
    input  logic    in_valid,  // Item issued this cycle
    output mac_op_t op,        // Operation for this cycle
    output result_t c          // Bias register
);

    mac_op_t      op_q;   // Stored operation word
    result_t      c_q;    // Stored bias
    issue_state_e issue;  // Item or idle this cycle

    // --------------------
    // Host writes
    // --------------------
    // New values take effect from the cycle after the strobe
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            op_q <= mac_op_t'(`MAC_OP_HOLD);
            c_q  <= '0;
        end else if (wr_en) begin
            case (wr_addr)
                `MAC_ADDR_OP: op_q <= mac_op_t'(wr_data[$bits(mac_op_t)-1:0]);  // Low bits
                `MAC_ADDR_C:  c_q  <= wr_data;
            endcase
        end
    end

    // --------------------
    // Operation issue
    // --------------------
    assign issue = in_valid ? ISSUE_OP : ISSUE_HOLD;

    always_comb begin
        case (issue)
            ISSUE_OP: op = op_q;                       // Stored word for a valid item
            default:  op = mac_op_t'(`MAC_OP_HOLD);    // Idle cycles leave P alone
        endcase
    end

    assign c = c_q;

endmodule

// ==== alu_dsp.sv ====
// MAC arithmetic wrapper
// Delays bias and operation word to meet the slice multiplier stage,
// unpacks the operation word and tracks result validity
`timescale 1ns/1ps
`include "mac_consts.svh"

module alu_dsp
    import mac_data_pkg::*;
    import mac_op_pkg::*;
(
    input  logic     reset,      // Clock
    input  logic     clk,        // Async reset, active high
    input  logic     in_valid,   // One pulse per operand pair
    input  mac_op_t  op,
    input  operand_t a,
    input  operand_t b,
    input  result_t  c,
    output result_t  p,
    output logic     out_valid   // Pulse when p shows a new item
);

    result_t                 c_dly;     // Bias aligned to the A1/B1 stage
    mac_op_t                 op_dly;    // Operation aligned to the A1/B1 stage
    logic [`MAC_LATENCY-1:0] valid_sr;  // One bit per pipeline stage

    // --------------------
    // Alignment registers
    // --------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            c_dly    <= '0;
            op_dly   <= '0;
            valid_sr <= '0;
        end else begin
            c_dly    <= c;
            op_dly   <= op;
            valid_sr <= {valid_sr[`MAC_LATENCY-2:0], in_valid};
        end
    end

    assign out_valid = valid_sr[`MAC_LATENCY-1];  // Rises with P of the same item

    // --------------------
    // Slice
    // --------------------
    dsp_slice i_dsp_slice (
        .reset    (reset          ),
        .clk      (clk            ),
        .a        (a              ),
        .b        (b              ),
        .c        (c_dly          ),  // Registered again as CREG
        .x_sel    (op_dly.x_sel   ),
        .z_sel    (op_dly.z_sel   ),
        .carry_in (op_dly.carry_in),
        .subtract (op_dly.subtract),
        .p        (p              )
    );

endmodule

// ==== dsp_slice.sv ====
// DSP slice model
// Signed 18x18 multiplier with A1/B1, M, C, opmode and P registers
// and a post-adder/subtracter computing P = Z +/- (X + carry)
`timescale 1ns/1ps
`include "mac_consts.svh"

module dsp_slice
    import mac_data_pkg::*;
    import mac_op_pkg::*;
(
    input  logic     reset,     // Clock
    input  logic     clk,       // Async reset, active high
    input  operand_t a,
    input  operand_t b,
    input  result_t  c,         // Bias, one cycle ahead of the product
    input  x_sel_e   x_sel,     // Opmode fields, also one cycle ahead
    input  z_sel_e   z_sel,
    input  logic     carry_in,
    input  logic     subtract,
    output result_t  p
);

    localparam int EXT_W = `MAC_P_W - `MAC_M_W;  // Sign bits added to 36-bit words

    // --------------------
    // Pipeline registers
    // --------------------
    operand_t a1_q;     // Stage 1 A
    operand_t b1_q;     // Stage 1 B
    product_t m_q;      // Stage 2 product
    product_t ab_q;     // Stage 2 A:B, kept in step with M
    result_t  c_q;      // C register
    x_sel_e   x_sel_q;  // Opmode registers
    z_sel_e   z_sel_q;
    logic     carry_q;
    logic     sub_q;
    result_t  p_q;      // Stage 3 result

    result_t  m_ext;    // Product widened to 48 bits
    result_t  ab_ext;   // A:B widened to 48 bits
    result_t  x_mux;
    result_t  z_mux;
    result_t  x_total;  // X plus carry
    result_t  p_next;

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            a1_q    <= '0;
            b1_q    <= '0;
            m_q     <= '0;
            ab_q    <= '0;
            c_q     <= '0;
            x_sel_q <= X_ZERO;
            z_sel_q <= Z_ZERO;
            carry_q <= 1'b0;
            sub_q   <= 1'b0;
            p_q     <= '0;
        end else begin
            a1_q    <= a;
            b1_q    <= b;
            m_q     <= a1_q * b1_q;      // Signed 18x18
            ab_q    <= {a1_q, b1_q};
            c_q     <= c;
            x_sel_q <= x_sel;
            z_sel_q <= z_sel;
            carry_q <= carry_in;
            sub_q   <= subtract;
            p_q     <= p_next;
        end
    end

    // --------------------
    // Post-adder
    // --------------------
    assign m_ext  = {{EXT_W{m_q[`MAC_M_W-1]}}, m_q};
    assign ab_ext = {{EXT_W{ab_q[`MAC_M_W-1]}}, ab_q};

    always_comb begin
        case (x_sel_q)
            X_PROD:  x_mux = m_ext;
            X_P:     x_mux = p_q;    // Feedback of the previous item
            X_AB:    x_mux = ab_ext;
            default: x_mux = '0;
        endcase
    end

    always_comb begin
        case (z_sel_q)
            Z_P:     z_mux = p_q;
            Z_C:     z_mux = c_q;
            default: z_mux = '0;     // Zero and the reserved code
        endcase
    end

    assign x_total = x_mux + result_t'(carry_q);            // Carry zero-extended
    assign p_next  = sub_q ? (z_mux - x_total) : (z_mux + x_total);

    assign p = p_q;

endmodule

// ==== mac_op_pkg.sv ====
// MAC operation encoding
// Post-adder input selects, the packed operation word and the
// issue state used by the register block

package mac_op_pkg;

    // X input of the post-adder
    typedef enum logic [1:0] {
        X_ZERO = 2'd0,  // Constant zero
        X_PROD = 2'd1,  // Registered product
        X_P    = 2'd2,  // P feedback
        X_AB   = 2'd3   // Sign-extended A:B
    } x_sel_e;

    // Z input of the post-adder, code 2 reads as zero
    typedef enum logic [1:0] {
        Z_ZERO = 2'd0,  // Constant zero
        Z_P    = 2'd1,  // P feedback for accumulate
        Z_C    = 2'd3   // Bias register
    } z_sel_e;

    // Operation word, P = Z +/- (X + carry)
    typedef struct packed {
        logic   subtract;  // 1 gives Z - (X + carry)
        logic   carry_in;  // Carry into the X sum
        z_sel_e z_sel;
        x_sel_e x_sel;
    } mac_op_t;

    // What the register block sends down each cycle
    typedef enum logic {
        ISSUE_HOLD = 1'b0,  // Idle cycle, P unchanged
        ISSUE_OP   = 1'b1   // Valid item, stored word
    } issue_state_e;

endpackage

// ==== mac_data_pkg.sv ====
// MAC data types
// Signed vector types for operands, products and the accumulator
`include "mac_consts.svh"

package mac_data_pkg;

    // --------------------
    // Arithmetic words
    // --------------------

    // A and B operands from the host
    typedef logic signed [`MAC_A_W-1:0] operand_t;

    // Multiplier output, also holds the A:B concatenation
    typedef logic signed [`MAC_M_W-1:0] product_t;

    // P result, C bias and host write data
    typedef logic signed [`MAC_P_W-1:0] result_t;

endpackage

// ==== mac_consts.svh ====
// MAC unit constants
// Datapath widths, pipeline latency, register map and the idle
// operation word shared by the packages and the RTL
`ifndef MAC_CONSTS_SVH
`define MAC_CONSTS_SVH

// --------------------
// Datapath widths
// --------------------
`define MAC_A_W 18  // A and B operand width
`define MAC_M_W 36  // Full signed product width
`define MAC_P_W 48  // Accumulator and result width

// --------------------
// Pipeline
// --------------------
`define MAC_LATENCY 3  // A1/B1, M and P stages

// --------------------
// Register map
// --------------------
`define MAC_ADDR_OP 1'b0  // Operation word register
`define MAC_ADDR_C  1'b1  // Bias register

// Idle word computes P = P + 0 with no carry
// Field order is subtract, carry_in, z_sel (Z_P), x_sel (X_ZERO)
`define MAC_OP_HOLD 6'b0_0_01_00

`endif
